//--- src/icache_pkg.sv
// ###################################################################
// Instruction cache widths, geometry and sideband field types
// Fetch request, decoder response and refill line structs
// ###################################################################

`default_nettype none

package icache_pkg;

    // ###############################################################
    // Widths and geometry
    // ###############################################################

    // One PC is one instruction word
    localparam int unsigned PC_W   = 32;
    localparam int unsigned INST_W = 32;

    // Two instructions per line
    localparam int unsigned LINE_WORDS_LOG2 = 1;
    localparam int unsigned LINE_WORDS      = 1 << LINE_WORDS_LOG2;

    // Direct mapped, 32 lines
    localparam int unsigned NUM_LINES   = 32;
    localparam int unsigned INDEX_W     = $clog2(NUM_LINES);
    localparam int unsigned TAG_W       = PC_W - INDEX_W - LINE_WORDS_LOG2;
    localparam int unsigned LINE_ADDR_W = PC_W - LINE_WORDS_LOG2;

    // Warp sideband
    localparam int unsigned NUM_WARPS  = 8;
    localparam int unsigned WARP_ID_W  = $clog2(NUM_WARPS);
    localparam int unsigned WARP_WIDTH = 32;
    localparam int unsigned SUBWARP_W  = $clog2(WARP_WIDTH);

    // ###############################################################
    // Field types
    // ###############################################################

    typedef logic [PC_W-1:0]            pc_t;
    typedef logic [INST_W-1:0]          inst_t;
    typedef logic [TAG_W-1:0]           tag_t;
    typedef logic [INDEX_W-1:0]         index_t;
    typedef logic [LINE_WORDS_LOG2-1:0] offset_t;
    typedef logic [LINE_ADDR_W-1:0]     line_addr_t;
    typedef logic [WARP_WIDTH-1:0]      act_mask_t;
    typedef logic [WARP_ID_W-1:0]       warp_id_t;
    typedef logic [SUBWARP_W-1:0]       subwarp_id_t;

    // PC seen by the lookup and hit test
    typedef struct packed {
        tag_t    tag;
        index_t  index;
        offset_t offset;
    } pc_split_t;

    // PC seen by the memory port and word select
    typedef struct packed {
        line_addr_t line_addr;
        offset_t    offset;
    } pc_line_t;

    // Same PC word, two decodings
    typedef union packed {
        pc_split_t split;
        pc_line_t  line;
    } pc_fields_u;

    // Fetcher request, 72 bits
    typedef struct packed {
        pc_t         pc;
        act_mask_t   act_mask;
        warp_id_t    warp_id;
        subwarp_id_t subwarp_id;
    } fetch_req_t;

    // Whole cache line, word 0 in the low bits
    typedef inst_t [LINE_WORDS-1:0] line_t;

    // Decoder payload
    typedef struct packed {
        pc_t         pc;
        act_mask_t   act_mask;
        warp_id_t    warp_id;
        subwarp_id_t subwarp_id;
        inst_t       inst;
    } dec_resp_t;

endpackage

`default_nettype wire

//--- src/icache_line_store.sv
// ###################################################################
// Tag array, line array and valid bits of the direct-mapped cache
// Registered lookup read, refill write and whole-cache flush clear
// ###################################################################

`timescale 1ns/10ps
`default_nettype none

module icache_line_store (
    input  logic                  clk_i,
    input  logic                  rst_n_i,

    // Lookup port, result one cycle later
    input  logic                  lookup_i,
    input  icache_pkg::index_t    lookup_index_i,

    // Refill write port
    input  logic                  write_i,
    input  icache_pkg::index_t    write_index_i,
    input  icache_pkg::tag_t      write_tag_i,
    input  icache_pkg::line_t     write_line_i,

    // Invalidate every line
    input  logic                  flush_clear_i,

    // Registered lookup result
    output icache_pkg::tag_t      tag_o,
    output logic                  valid_o,
    output icache_pkg::line_t     line_o
);

    // ###############################################################
    // Storage
    // ###############################################################

    // Tag and data arrays
    icache_pkg::tag_t  tag_mem  [icache_pkg::NUM_LINES];
    icache_pkg::line_t line_mem [icache_pkg::NUM_LINES];

    // One valid bit per line
    logic [icache_pkg::NUM_LINES-1:0] valid_q;

    // ###############################################################
    // Array write and read
    // ###############################################################

    // Refill writes tag and line together
    always_ff @(posedge clk_i) begin : array_write
        if (write_i) begin
            tag_mem[write_index_i]  <= write_tag_i;
            line_mem[write_index_i] <= write_line_i;
        end
    end

    // Registered read
    // Output holds between lookups so a stalled hit stays stable
    always_ff @(posedge clk_i) begin : array_read
        if (lookup_i) begin
            tag_o  <= tag_mem[lookup_index_i];
            line_o <= line_mem[lookup_index_i];
        end
    end

    // ###############################################################
    // Valid bits
    // ###############################################################

    // Flush wins over a refill
    // The controller never raises both in one cycle
    always_ff @(posedge clk_i) begin : valid_bits
        if (!rst_n_i) begin
            valid_q <= '0;
        end else if (flush_clear_i) begin
            valid_q <= '0;
        end else if (write_i) begin
            valid_q[write_index_i] <= 1'b1;
        end
    end

    // Valid bit read alongside the tag
    always_ff @(posedge clk_i) begin : valid_read
        if (!rst_n_i) begin
            valid_o <= 1'b0;
        end else if (lookup_i) begin
            valid_o <= valid_q[lookup_index_i];
        end
    end

endmodule

`default_nettype wire

//--- src/icache_controller.sv
// ###################################################################
// Cache control FSM with request register and hit test
// Miss request to memory and pending flush handling
// ###################################################################

`timescale 1ns/10ps
`default_nettype none

module icache_controller (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  logic                    flush_i,

    // Fetch port
    input  logic                    fe_valid_i,
    input  icache_pkg::fetch_req_t  fe_req_i,
    output logic                    ic_ready_o,

    // Memory request and response strobe
    output logic                    mem_req_o,
    output icache_pkg::line_addr_t  mem_addr_o,
    input  logic                    mem_ready_i,
    input  logic                    mem_valid_i,

    // Line store lookup
    output logic                    lookup_o,
    output icache_pkg::index_t      lookup_index_o,
    input  icache_pkg::tag_t        lookup_tag_i,
    input  logic                    lookup_valid_i,

    // Line store refill and flush
    output logic                    write_o,
    output icache_pkg::index_t      write_index_o,
    output icache_pkg::tag_t        write_tag_o,
    output logic                    flush_clear_o,

    // Instruction select
    output icache_pkg::fetch_req_t  active_req_o,
    output logic                    hit_deliver_o,
    output logic                    refill_deliver_o,
    input  logic                    resp_taken_i
);

    // ###############################################################
    // Declarations
    // ###############################################################

    typedef enum logic [1:0] {
        S_IDLE     = 2'd0, // nothing in flight
        S_HANDLE   = 2'd1, // lookup result present
        S_WAIT_MEM = 2'd2, // miss request sent
        S_WAIT_DEC = 2'd3  // refill line waiting for decoder
    } state_e;

    state_e state_q;
    state_e state_d;

    // Request in flight and pending flush
    icache_pkg::fetch_req_t active_req_q;
    logic                   flush_q;

    // PC decodes of incoming and active request
    icache_pkg::pc_fields_u fe_pc;
    icache_pkg::pc_fields_u act_pc;

    logic hit;
    logic boundary;
    logic flush_take;
    logic accept;

    // ###############################################################
    // Hit test and handshakes
    // ###############################################################

    assign fe_pc  = fe_req_i.pc;
    assign act_pc = active_req_q.pc;

    // Store output is valid only in S_HANDLE
    assign hit = lookup_valid_i && (lookup_tag_i == act_pc.split.tag);

    // Request boundary
    // Idle, or the current response leaves this cycle
    assign boundary = (state_q == S_IDLE) || resp_taken_i;

    // Pending flush blocks the fetcher for one cycle
    assign flush_take = boundary && flush_q;
    assign ic_ready_o = boundary && !flush_q;
    assign accept     = ic_ready_o && fe_valid_i;

    // Lookup with the incoming request
    assign lookup_o       = accept;
    assign lookup_index_o = fe_pc.split.index;

    // Refill into the active request's line
    assign write_o       = (state_q == S_WAIT_MEM) && mem_valid_i;
    assign write_index_o = act_pc.split.index;
    assign write_tag_o   = act_pc.split.tag;
    assign flush_clear_o = flush_take;

    // Miss request held until memory takes it
    assign mem_req_o  = (state_q == S_HANDLE) && !hit;
    assign mem_addr_o = act_pc.line.line_addr;

    // Response source
    assign hit_deliver_o    = (state_q == S_HANDLE) && hit;
    assign refill_deliver_o = (state_q == S_WAIT_DEC);
    assign active_req_o     = active_req_q;

    // ###############################################################
    // FSM
    // ###############################################################

    always_comb begin : next_state
        state_d = state_q;
        if (accept) begin
            // Back to back request
            state_d = S_HANDLE;
        end else if (boundary) begin
            // Response gone, or flush taken
            state_d = S_IDLE;
        end else begin
            case (state_q)
                S_HANDLE: begin
                    if (mem_req_o && mem_ready_i) begin
                        state_d = S_WAIT_MEM;
                    end
                end
                S_WAIT_MEM: begin
                    if (mem_valid_i) begin
                        state_d = S_WAIT_DEC;
                    end
                end
                default: begin
                    state_d = state_q;
                end
            endcase
        end
    end

    // State and flush flag
    // A flush arriving in the take cycle stays pending
    always_ff @(posedge clk_i) begin : control_regs
        if (!rst_n_i) begin
            state_q <= S_IDLE;
            flush_q <= 1'b0;
        end else begin
            state_q <= state_d;
            flush_q <= (flush_q && !flush_take) || flush_i;
        end
    end

    // Request payload
    always_ff @(posedge clk_i) begin : request_reg
        if (accept) begin
            active_req_q <= fe_req_i;
        end
    end

    // ###############################################################
    // Assertions
    // ###############################################################

    // Memory answers only an accepted request
    mem_resp_in_wait: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        mem_valid_i |-> (state_q == S_WAIT_MEM)
    ) else $error("mem_valid_i outside of the memory wait state");

endmodule

`default_nettype wire

//--- src/icache_inst_select.sv
// ###################################################################
// Refill line buffer and instruction word select
// Decoder port drive and handshake result
// ###################################################################

`timescale 1ns/10ps
`default_nettype none

module icache_inst_select (
    input  logic                    clk_i,
    input  logic                    rst_n_i,

    // Memory response strobe
    input  logic                    mem_valid_i,
    input  icache_pkg::line_t       mem_data_i,

    // From line store and controller
    input  icache_pkg::line_t       lookup_line_i,
    input  icache_pkg::fetch_req_t  active_req_i,
    input  logic                    hit_deliver_i,
    input  logic                    refill_deliver_i,

    // Decoder port
    input  logic                    dec_ready_i,
    output logic                    ic_valid_o,
    output icache_pkg::dec_resp_t   ic_resp_o,
    output logic                    resp_taken_o
);

    icache_pkg::line_t      refill_q;
    icache_pkg::line_t      src_line;
    icache_pkg::pc_fields_u req_pc;

    // Refill line kept until the decoder takes it
    always_ff @(posedge clk_i) begin : refill_buffer
        if (mem_valid_i) begin
            refill_q <= mem_data_i;
        end
    end

    assign req_pc   = active_req_i.pc;
    assign src_line = refill_deliver_i ? refill_q : lookup_line_i;

    // Sideband passes straight through
    always_comb begin : resp_build
        ic_resp_o.pc         = active_req_i.pc;
        ic_resp_o.act_mask   = active_req_i.act_mask;
        ic_resp_o.warp_id    = active_req_i.warp_id;
        ic_resp_o.subwarp_id = active_req_i.subwarp_id;
        // Word picked by line offset
        ic_resp_o.inst       = src_line[req_pc.line.offset];
    end

    assign ic_valid_o   = hit_deliver_i || refill_deliver_i;
    assign resp_taken_o = ic_valid_o && dec_ready_i;

    // Stalled response must not move
    resp_held: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        (ic_valid_o && !dec_ready_i) |=> (ic_valid_o && $stable(ic_resp_o))
    ) else $error("ic_resp_o changed under decoder back-pressure");

endmodule

`default_nettype wire

//--- src/icache_top.sv
// ###################################################################
// Instruction cache top level
// ###################################################################

`timescale 1ns/10ps
`default_nettype none

module icache_top (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  logic                    flush_i,

    // Fetch port
    input  logic                    fe_valid_i,
    input  icache_pkg::fetch_req_t  fe_req_i,
    output logic                    ic_ready_o,

    // Memory port
    output logic                    mem_req_o,
    output icache_pkg::line_addr_t  mem_addr_o,
    input  logic                    mem_ready_i,
    input  logic                    mem_valid_i,
    input  icache_pkg::line_t       mem_data_i,

    // Decoder port
    output logic                    ic_valid_o,
    output icache_pkg::dec_resp_t   ic_resp_o,
    input  logic                    dec_ready_i
);

    // Controller to line store
    logic                   lookup;
    icache_pkg::index_t     lookup_index;
    icache_pkg::tag_t       lookup_tag;
    logic                   lookup_valid;
    icache_pkg::line_t      lookup_line;
    logic                   write;
    icache_pkg::index_t     write_index;
    icache_pkg::tag_t       write_tag;
    logic                   flush_clear;

    // Controller to instruction select
    icache_pkg::fetch_req_t active_req;
    logic                   hit_deliver;
    logic                   refill_deliver;
    logic                   resp_taken;

    icache_controller ctrl0 (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .flush_i          (flush_i),
        .fe_valid_i       (fe_valid_i),
        .fe_req_i         (fe_req_i),
        .ic_ready_o       (ic_ready_o),
        .mem_req_o        (mem_req_o),
        .mem_addr_o       (mem_addr_o),
        .mem_ready_i      (mem_ready_i),
        .mem_valid_i      (mem_valid_i),
        .lookup_o         (lookup),
        .lookup_index_o   (lookup_index),
        .lookup_tag_i     (lookup_tag),
        .lookup_valid_i   (lookup_valid),
        .write_o          (write),
        .write_index_o    (write_index),
        .write_tag_o      (write_tag),
        .flush_clear_o    (flush_clear),
        .active_req_o     (active_req),
        .hit_deliver_o    (hit_deliver),
        .refill_deliver_o (refill_deliver),
        .resp_taken_i     (resp_taken)
    );

    // Refill line comes straight from memory
    icache_line_store store0 (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .lookup_i       (lookup),
        .lookup_index_i (lookup_index),
        .write_i        (write),
        .write_index_i  (write_index),
        .write_tag_i    (write_tag),
        .write_line_i   (mem_data_i),
        .flush_clear_i  (flush_clear),
        .tag_o          (lookup_tag),
        .valid_o        (lookup_valid),
        .line_o         (lookup_line)
    );

    icache_inst_select sel0 (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .mem_valid_i      (mem_valid_i),
        .mem_data_i       (mem_data_i),
        .lookup_line_i    (lookup_line),
        .active_req_i     (active_req),
        .hit_deliver_i    (hit_deliver),
        .refill_deliver_i (refill_deliver),
        .dec_ready_i      (dec_ready_i),
        .ic_valid_o       (ic_valid_o),
        .ic_resp_o        (ic_resp_o),
        .resp_taken_o     (resp_taken)
    );

endmodule

`default_nettype wire

//--- testbench/icache_mem_model.sv
// ###################################################################
// Line memory responder with random ready and random latency
// Line words are a fixed function of each word's PC
// ###################################################################

`timescale 1ns/10ps
`default_nettype none

module icache_mem_model #(
    parameter logic [31:0] SEED = 32'he9f2
) (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic                   mem_req_i,
    input  icache_pkg::line_addr_t mem_addr_i,
    output logic                   mem_ready_o,
    output logic                   mem_valid_o,
    output icache_pkg::line_t      mem_data_o
);

    logic [31:0]            rng;
    logic                   busy;
    logic [2:0]             delay;
    icache_pkg::line_addr_t addr_q;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Content rule, one word per PC
    function automatic icache_pkg::inst_t word_for_pc(input icache_pkg::pc_t pc);
        return (pc * 32'h9e37_79b1) ^ 32'h0bad_c0de;
    endfunction

    function automatic icache_pkg::line_t line_for_addr(input icache_pkg::line_addr_t la);
        icache_pkg::line_t line;
        icache_pkg::pc_t   pc;
        for (int w = 0; w < icache_pkg::LINE_WORDS; w++) begin
            pc      = (icache_pkg::pc_t'(la) << icache_pkg::LINE_WORDS_LOG2) | icache_pkg::pc_t'(w);
            line[w] = word_for_pc(pc);
        end
        return line;
    endfunction

    // One request at a time, answered 1 to 8 cycles after the handshake
    always @(posedge clk_i) begin : respond
        if (!rst_n_i) begin
            rng         <= SEED;
            busy        <= 1'b0;
            delay       <= 3'd0;
            addr_q      <= '0;
            mem_ready_o <= 1'b0;
            mem_valid_o <= 1'b0;
            mem_data_o  <= '0;
        end else begin
            rng         <= xorshift32(rng);
            mem_valid_o <= 1'b0;
            if (mem_req_i && mem_ready_o) begin
                busy        <= 1'b1;
                addr_q      <= mem_addr_i;
                delay       <= rng[2:0];
                mem_ready_o <= 1'b0;
            end else if (busy) begin
                if (delay == 3'd0) begin
                    // Single-cycle response strobe
                    mem_valid_o <= 1'b1;
                    mem_data_o  <= line_for_addr(addr_q);
                    busy        <= 1'b0;
                end else begin
                    delay <= delay - 3'd1;
                end
            end else begin
                mem_ready_o <= rng[4];
            end
        end
    end

endmodule

`default_nettype wire

//--- testbench/tb_icache.sv
// ###################################################################
// Instruction cache testbench with reference function and tag model
// Directed and random fetch streams, response checks, timeout
// ###################################################################

`timescale 1ns/10ps
`default_nettype none

module tb_icache;

    localparam logic [31:0] SEED       = 32'he9f2;
    localparam int          N_RANDOM   = 300;
    // About 60 cycles per request covers random ready and latency
    localparam int          MAX_CYCLES = (N_RANDOM + 24) * 60;
    localparam logic [1:0]  READY_HIGH = 2'd0;
    localparam logic [1:0]  READY_LOW  = 2'd1;
    localparam logic [1:0]  READY_RAND = 2'd2;

    logic                   clk_i;
    logic                   rst_n_i;
    logic                   flush_i;
    logic                   fe_valid_i;
    icache_pkg::fetch_req_t fe_req_i;
    logic                   ic_ready_o;
    logic                   mem_req_o;
    icache_pkg::line_addr_t mem_addr_o;
    logic                   mem_ready_i;
    logic                   mem_valid_i;
    icache_pkg::line_t      mem_data_i;
    logic                   ic_valid_o;
    icache_pkg::dec_resp_t  ic_resp_o;
    logic                   dec_ready_i = 1'b0;

    // Scoreboard and tag model
    icache_pkg::dec_resp_t            exp_q[$];
    logic                             hit_q[$];
    icache_pkg::line_addr_t           mem_addr_q[$];
    icache_pkg::tag_t                 model_tag [icache_pkg::NUM_LINES];
    logic [icache_pkg::NUM_LINES-1:0] model_valid;
    logic                             after_accept;
    logic                             after_hit;
    logic                             post_reset;
    logic                             stall_seen;
    icache_pkg::dec_resp_t            stall_resp;

    int          checks = 0;
    int          errors = 0;
    int          hits = 0;
    int          misses = 0;
    int          cycles = 0;
    int          mark_checks = 0;
    int          mark_errors = 0;
    logic [31:0] rng_stim;
    logic [31:0] rng_ready = SEED ^ 32'h5555_0000;
    logic [1:0]  ready_mode;

    icache_top dut0 (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .flush_i     (flush_i),
        .fe_valid_i  (fe_valid_i),
        .fe_req_i    (fe_req_i),
        .ic_ready_o  (ic_ready_o),
        .mem_req_o   (mem_req_o),
        .mem_addr_o  (mem_addr_o),
        .mem_ready_i (mem_ready_i),
        .mem_valid_i (mem_valid_i),
        .mem_data_i  (mem_data_i),
        .ic_valid_o  (ic_valid_o),
        .ic_resp_o   (ic_resp_o),
        .dec_ready_i (dec_ready_i)
    );

    icache_mem_model #(.SEED(SEED ^ 32'h0000_3c00)) mem0 (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .mem_req_i   (mem_req_o),
        .mem_addr_i  (mem_addr_o),
        .mem_ready_o (mem_ready_i),
        .mem_valid_o (mem_valid_i),
        .mem_data_o  (mem_data_i)
    );

    // ###############################################################
    // Helpers
    // ###############################################################

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Expected instruction at any PC
    function automatic icache_pkg::inst_t ref_inst(input icache_pkg::pc_t pc);
        return (pc * 32'h9e37_79b1) ^ 32'h0bad_c0de;
    endfunction

    task automatic report_mismatch(input string msg);
        errors++;
        $display("Mismatch at %0t: %s", $time, msg);
    endtask

    task automatic send_fetch(input icache_pkg::pc_t pc, input icache_pkg::act_mask_t mask,
                              input icache_pkg::warp_id_t warp,
                              input icache_pkg::subwarp_id_t sub);
        fe_valid_i <= 1'b1;
        fe_req_i   <= '{pc: pc, act_mask: mask, warp_id: warp, subwarp_id: sub};
        // Held until the cache takes it
        @(posedge clk_i);
        while (!ic_ready_o) @(posedge clk_i);
        fe_valid_i <= 1'b0;
    endtask

    task automatic pulse_flush();
        flush_i <= 1'b1;
        @(posedge clk_i);
        flush_i <= 1'b0;
    endtask

    // Queue read at the falling edge, after the compare process ran
    task automatic wait_drained();
        @(negedge clk_i);
        while (exp_q.size() != 0) @(negedge clk_i);
        @(posedge clk_i);
    endtask

    // Response shown, decoder kept off for a while, then released
    task automatic stall_decoder(input int cycles_held);
        @(posedge clk_i);
        while (!ic_valid_o) @(posedge clk_i);
        repeat (cycles_held) @(posedge clk_i);
        ready_mode <= READY_HIGH;
        wait_drained();
    endtask

    task automatic finish_test(input string name);
        $display("test %-12s %0d checks, %0d errors", name,
                 checks - mark_checks, errors - mark_errors);
        mark_checks = checks;
        mark_errors = errors;
    endtask

    // ###############################################################
    // Clock, decoder ready, timeout
    // ###############################################################

    initial begin : clock_gen
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin : ready_gen
        rng_ready = xorshift32(rng_ready);
        case (ready_mode)
            READY_HIGH: dec_ready_i <= 1'b1;
            READY_LOW:  dec_ready_i <= 1'b0;
            default:    dec_ready_i <= rng_ready[5] | rng_ready[12];
        endcase
    end

    always @(posedge clk_i) begin : watchdog
        cycles++;
        if (cycles > MAX_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("*** FAILED ***");
            $finish;
        end
    end

    // ###############################################################
    // Comparison against the reference and tag model
    // ###############################################################

    always @(posedge clk_i) begin : compare
        icache_pkg::dec_resp_t want;
        logic                  want_hit;
        icache_pkg::index_t    idx;
        icache_pkg::tag_t      tag;
        if (!rst_n_i) begin
            model_valid  = '0;
            after_accept = 1'b0;
            stall_seen   = 1'b0;
            post_reset   = 1'b1;
        end else begin
            if (post_reset) begin
                checks++;
                assert (ic_ready_o && !ic_valid_o && !mem_req_o)
                else report_mismatch("ready, valid or mem_req wrong after reset");
                post_reset = 1'b0;
            end
            // Cycle after acceptance, hit shows data, miss asks memory
            if (after_accept) begin
                checks++;
                assert (after_hit ? (ic_valid_o && !mem_req_o) : (mem_req_o && !ic_valid_o))
                else report_mismatch($sformatf("hit %0b timing wrong, valid %0b mem_req %0b",
                                               after_hit, ic_valid_o, mem_req_o));
            end
            after_accept = 1'b0;
            // Stalled response must hold
            if (stall_seen) begin
                checks++;
                assert (ic_valid_o && ic_resp_o == stall_resp)
                else report_mismatch("response moved under back-pressure");
            end
            stall_seen = ic_valid_o && !dec_ready_i;
            stall_resp = ic_resp_o;
            // Fetch port closed while the decoder stalls
            if (stall_seen) begin
                checks++;
                assert (!ic_ready_o)
                else report_mismatch("ic_ready_o high while the response is stalled");
            end
            if (mem_req_o && mem_ready_i) begin
                mem_addr_q.push_back(mem_addr_o);
            end
            if (ic_valid_o && dec_ready_i) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("Decoder received a response with no request outstanding");
                end else begin
                    want     = exp_q.pop_front();
                    want_hit = hit_q.pop_front();
                    checks++;
                    assert (ic_resp_o == want)
                    else report_mismatch($sformatf(
                        "pc %h got inst %h side %h/%0d/%0d, want %h %h/%0d/%0d",
                        want.pc, ic_resp_o.inst, ic_resp_o.act_mask, ic_resp_o.warp_id,
                        ic_resp_o.subwarp_id, want.inst, want.act_mask, want.warp_id,
                        want.subwarp_id));
                    checks++;
                    assert (mem_addr_q.size() == (want_hit ? 0 : 1)
                            && (want_hit || mem_addr_q[0] == icache_pkg::line_addr_t'(
                                want.pc >> icache_pkg::LINE_WORDS_LOG2)))
                    else report_mismatch($sformatf("pc %h saw %0d memory requests, hit %0b",
                                                   want.pc, mem_addr_q.size(), want_hit));
                    mem_addr_q.delete();
                end
            end
            // Acceptance, predicted by the tag model
            if (ic_ready_o && fe_valid_i) begin
                idx      = fe_req_i.pc[icache_pkg::LINE_WORDS_LOG2 +: icache_pkg::INDEX_W];
                tag      = fe_req_i.pc[icache_pkg::PC_W-1 -: icache_pkg::TAG_W];
                want_hit = model_valid[idx] && (model_tag[idx] == tag);
                model_valid[idx] = 1'b1;
                model_tag[idx]   = tag;
                want.pc         = fe_req_i.pc;
                want.act_mask   = fe_req_i.act_mask;
                want.warp_id    = fe_req_i.warp_id;
                want.subwarp_id = fe_req_i.subwarp_id;
                want.inst       = ref_inst(fe_req_i.pc);
                exp_q.push_back(want);
                hit_q.push_back(want_hit);
                after_accept = 1'b1;
                after_hit    = want_hit;
                if (want_hit) hits++;
                else misses++;
            end
            // Flush lands before the next acceptance
            if (flush_i) model_valid = '0;
        end
    end

    // ###############################################################
    // Test sequence
    // ###############################################################

    initial begin : main
        rst_n_i    = 1'b0;
        flush_i    = 1'b0;
        fe_valid_i = 1'b0;
        fe_req_i   = '0;
        ready_mode = READY_HIGH;
        rng_stim   = SEED;
        repeat (2) @(posedge clk_i);
        rst_n_i <= 1'b1;
        @(posedge clk_i);
        @(posedge clk_i);
        finish_test("reset");

        send_fetch(32'h0000_0104, 32'hffff_ffff, 3'd1, 5'd0);
        wait_drained();
        finish_test("cold_miss");

        // Same line, both words
        send_fetch(32'h0000_0104, 32'h0000_ffff, 3'd2, 5'd3);
        send_fetch(32'h0000_0105, 32'hffff_0000, 3'd5, 5'd17);
        wait_drained();
        finish_test("hit");

        // Index 2, tags 4 and 5
        send_fetch(32'h0000_0144, 32'h0f0f_0f0f, 3'd3, 5'd1);
        send_fetch(32'h0000_0104, 32'hf0f0_f0f0, 3'd4, 5'd2);
        send_fetch(32'h0000_0144, 32'h1234_5678, 3'd6, 5'd9);
        send_fetch(32'h0000_0105, 32'h8765_4321, 3'd7, 5'd31);
        wait_drained();
        finish_test("conflict");

        // A held hit, then a held miss
        ready_mode <= READY_LOW;
        send_fetch(32'h0000_0104, 32'h0000_0001, 3'd0, 5'd4);
        stall_decoder(5);
        ready_mode <= READY_LOW;
        send_fetch(32'h0000_02a0, 32'h8000_0000, 3'd2, 5'd8);
        stall_decoder(5);
        finish_test("backpressure");

        pulse_flush();
        send_fetch(32'h0000_02a0, 32'haaaa_5555, 3'd1, 5'd5);
        send_fetch(32'h0000_0104, 32'h5555_aaaa, 3'd3, 5'd6);
        wait_drained();
        finish_test("flush");

        ready_mode <= READY_RAND;
        for (int i = 0; i < N_RANDOM; i++) begin
            rng_stim = xorshift32(rng_stim);
            if (rng_stim[31:28] == 4'h0) pulse_flush();
            send_fetch(rng_stim & 32'h0000_01ff, {rng_stim[15:0], rng_stim[31:16]},
                       rng_stim[20:18], rng_stim[26:22]);
        end
        wait_drained();
        finish_test("random");

        $display("total %0d checks, %0d errors, %0d hits, %0d misses",
                 checks, errors, hits, misses);
        if (errors == 0 && exp_q.size() == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
src/icache_pkg.sv
src/icache_line_store.sv
src/icache_controller.sv
src/icache_inst_select.sv
src/icache_top.sv
testbench/icache_mem_model.sv
testbench/tb_icache.sv

//--- run.sh
#!/bin/sh
# Build and run the instruction cache testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --top-module tb_icache \
    -f flist.f -o sim_icache \
    && ./obj_dir/sim_icache > sim.log 2>&1

cat sim.log

grep -q '^\*\*\* PASSED \*\*\*$' sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
